// ==== Makefile ====
# Verilator build and run of the reservation station testbench

VERILATOR ?= verilator
TOP       ?= rsTb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== include/rsConfig_macros.svh ====
`ifndef RS_CONFIG_MACROS_SVH
`define RS_CONFIG_MACROS_SVH

// station geometry, depth must stay a power of two
`define RS_DEPTH 16
`define RS_NUM_BUSES 4

// field widths
`define RS_TAG_BITS 8
`define RS_INST_BITS 32
`define RS_IMM_BITS 32

`endif

// ==== list.f ====
+incdir+include
verilog/rsIsaPkg.sv
verilog/rsQueuePkg.sv
verilog/rsSlotIf.sv
verilog/rsControl.sv
verilog/rsWakeup.sv
verilog/rsPayloadRam.sv
verilog/rsIssueSelect.sv
verilog/rsTop.sv
sim/rsTb.sv

// ==== sim/rsTb.sv ====
`timescale 1ns/100ps
`include "rsConfig_macros.svh"

module rsTb;
    import rsIsaPkg::*;
    import rsQueuePkg::*;

    localparam int clkPeriod   = 20;
    localparam int resetCycles = 10;
    localparam int numTests    = 6;
    localparam int drainLimit  = 40;   // cycles allowed for the station to empty
    localparam int testBudget  = drainLimit + 30;
    localparam int testCycles  = resetCycles + numTests * testBudget;
    localparam int depth       = `RS_DEPTH;

    typedef struct packed {
        logic       valid;
        rsPayload_t payload;
        physTag_t   src1;
        physTag_t   src2;
    } issueRec_t;

    logic clk, reset, dispatch, aluSrc2, memToReg, memRead, memWrite;
    logic [`RS_INST_BITS-1:0] instNum;
    logic [`RS_IMM_BITS-1:0]  imm;
    logic [2:0]               funct3;
    physTag_t                 rd, src1Tag, src2Tag;
    aluOp_e                   aluOp;
    logic                     src1Ready, src2Ready;
    logic [`RS_NUM_BUSES-1:0] wbValid;
    physTag_t [`RS_NUM_BUSES-1:0] wbTags;

    logic full, issueValid, issueAluSrc2, issueMemToReg, issueMemRead, issueMemWrite;
    logic [`RS_INST_BITS-1:0] issueInstNum;
    logic [`RS_IMM_BITS-1:0]  issueImm;
    logic [2:0]               issueFunct3;
    physTag_t                 issueRd, issueSrc1Tag, issueSrc2Tag;
    aluOp_e                   issueAluOp;

    rsPayload_t sentPayload, seenPayload;
    issueRec_t  expected;
    logic       expFull;

    // reference model state
    entryState_e mState [depth];
    rsPayload_t  mPayload [depth];
    physTag_t    mTag1 [depth];
    physTag_t    mTag2 [depth];
    logic        mRdy1 [depth];
    logic        mRdy2 [depth];
    int          mHead, mTail;

    logic [15:0] lfsr = 16'd12137;
    logic [`RS_INST_BITS-1:0] nextInst, wantInst, firstInst;
    int errors, testErrors, testsRun, dispatchedCount, issuedCount, issuedBefore, waited;
    physTag_t tagA [6];
    physTag_t tagB [6];
    logic     needB [6];
    physTag_t sharedTag;

    rsTop DUT (.*);

    assign sentPayload = '{instNum, rd, aluOp, funct3, aluSrc2, memToReg, memRead, memWrite, imm};
    assign seenPayload = '{issueInstNum, issueRd, issueAluOp, issueFunct3, issueAluSrc2,
                           issueMemToReg, issueMemRead, issueMemWrite, issueImm};

    always #(clkPeriod / 2) clk = ~clk;

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int k = 0; k < n; k++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 16'hB400 : 16'h0000);
            r    = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic busMatch(physTag_t tag, logic [`RS_NUM_BUSES-1:0] wv,
                                      physTag_t [`RS_NUM_BUSES-1:0] wt);
        logic m;
        m = 1'b0;
        for (int b = 0; b < `RS_NUM_BUSES; b++) begin
            m = m | (wv[b] && wt[b] == tag);
        end
        return m;
    endfunction

    function automatic void modelReset();
        for (int i = 0; i < depth; i++) begin
            mState[i] = slotFree;
        end
        mHead    = 0;
        mTail    = 0;
        expected = '0;
        expFull  = 1'b0;
    endfunction

    // one clock edge of the station, returns what shows on the issue ports afterwards
    function automatic issueRec_t modelStep(logic disp, rsPayload_t pay, physTag_t t1,
                                            physTag_t t2, logic r1, logic r2,
                                            logic [`RS_NUM_BUSES-1:0] wv,
                                            physTag_t [`RS_NUM_BUSES-1:0] wt);
        issueRec_t rec;
        int        pick;
        int        idx;
        rec  = '0;
        pick = -1;
        for (int k = 0; k < depth; k++) begin
            idx = (mHead + k) % depth;
            if (pick < 0 && mState[idx] == slotWaiting && mRdy1[idx] && mRdy2[idx]) begin
                pick = idx;
            end
        end
        if (pick >= 0) begin
            rec = '{1'b1, mPayload[pick], mTag1[pick], mTag2[pick]};
        end
        if (mState[mHead] == slotIssued) begin  // reclaim looks at the old state
            mState[mHead] = slotFree;
            mHead         = (mHead + 1) % depth;
        end
        for (int i = 0; i < depth; i++) begin
            if (mState[i] == slotWaiting) begin
                mRdy1[i] = mRdy1[i] | busMatch(mTag1[i], wv, wt);
                mRdy2[i] = mRdy2[i] | busMatch(mTag2[i], wv, wt);
            end
        end
        if (pick >= 0) begin
            mState[pick] = slotIssued;
        end
        if (disp) begin
            mState[mTail]   = slotWaiting;
            mPayload[mTail] = pay;
            mTag1[mTail]    = t1;
            mTag2[mTail]    = t2;
            mRdy1[mTail]    = r1 | busMatch(t1, wv, wt);
            mRdy2[mTail]    = r2 | busMatch(t2, wv, wt);
            mTail           = (mTail + 1) % depth;
        end
        return rec;
    endfunction

    function automatic logic modelFull();
        logic f;
        f = 1'b1;
        for (int i = 0; i < depth; i++) begin
            if (mState[i] == slotFree) f = 1'b0;
        end
        return f;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            modelReset();
        end else begin
            expected = modelStep(dispatch, sentPayload, src1Tag, src2Tag, src1Ready,
                                 src2Ready, wbValid, wbTags);
            expFull  = modelFull();
        end
    end

    // outputs settle at the rising edge, compare in the middle of the cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (full !== expFull) begin
                errors++;
                $display("ERR %0t: full is %b, expected %b", $time, full, expFull);
            end
            if (issueValid !== expected.valid) begin
                errors++;
                $display("ERR %0t: issueValid is %b, expected %b", $time, issueValid,
                         expected.valid);
            end else if (expected.valid && seenPayload !== expected.payload) begin
                errors++;
                $display("ERR %0t: payload of inst %0d wrong, got inst %0d", $time,
                         expected.payload.instNum, issueInstNum);
            end else if (expected.valid && {issueSrc1Tag, issueSrc2Tag} !==
                         {expected.src1, expected.src2}) begin
                errors++;
                $display("ERR %0t: source tags of inst %0d are %h %h, expected %h %h",
                         $time, issueInstNum, issueSrc1Tag, issueSrc2Tag,
                         expected.src1, expected.src2);
            end
            if (issueValid === 1'b1) issuedCount++;
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #2;
        dispatch = 1'b0;
        wbValid  = '0;
        for (int b = 0; b < `RS_NUM_BUSES; b++) begin
            wbTags[b] = physTag_t'(randBits(8));  // junk on idle buses
        end
    endtask

    task automatic setDispatch(logic r1, logic r2, physTag_t t1, physTag_t t2);
        dispatch  = 1'b1;
        instNum   = nextInst;
        nextInst  = nextInst + 1;
        rd        = physTag_t'(randBits(8));
        aluOp     = aluOp_e'(4'(randBits(4) % 12));
        funct3    = 3'(randBits(3));
        aluSrc2   = 1'(randBits(1));
        memToReg  = 1'(randBits(1));
        memRead   = 1'(randBits(1));
        memWrite  = 1'(randBits(1));
        imm       = randBits(32);
        src1Tag   = t1;
        src2Tag   = t2;
        src1Ready = r1;
        src2Ready = r2;
        dispatchedCount++;
    endtask

    task automatic setBroadcast(physTag_t tag);
        int b;
        b = int'(randBits($clog2(`RS_NUM_BUSES)));
        wbValid[b] = 1'b1;
        wbTags[b]  = tag;
    endtask

    task automatic expectIssue(logic want, logic [`RS_INST_BITS-1:0] inst);
        if (issueValid !== want || (want && issueInstNum !== inst)) begin
            errors++;
            $display("ERR %0t: issueValid %b inst %0d, expected %b inst %0d", $time,
                     issueValid, issueInstNum, want, inst);
        end
    endtask

    task automatic drainIssues();
        waited = 0;
        while (issuedCount != dispatchedCount && waited < drainLimit) begin
            nextCycle();
            waited++;
        end
        if (issuedCount != dispatchedCount) begin
            errors++;
            $display("station never issued all entries, %0d of %0d came out",
                     issuedCount, dispatchedCount);
        end
    endtask

    task automatic finishTest(string name);
        $display("test %0d %-24s %s", testsRun + 1, name,
                 errors == testErrors ? "ok" : "failed");
        testsRun++;
        testErrors = errors;
    endtask

    initial begin
        #((testCycles + 50) * clkPeriod);
        $display("timeout, the tests did not finish within %0d cycles", testCycles + 50);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        dispatch = 1'b0;
        {instNum, rd, funct3, aluSrc2, memToReg, memRead, memWrite, imm} = '0;
        aluOp = aluAdd;
        {src1Tag, src2Tag, src1Ready, src2Ready} = '0;
        wbValid = '0;
        wbTags = '0;
        nextInst = 1;
        {errors, testErrors, testsRun, dispatchedCount, issuedCount} = '0;
        repeat (resetCycles) @(posedge clk);
        #2;
        reset = 1'b0;

        repeat (5) begin
            if (issueValid !== 1'b0 || full !== 1'b0) begin
                errors++;
                $display("ERR %0t: issueValid or full high before any dispatch", $time);
            end
            nextCycle();
        end
        finishTest("reset state");

        wantInst = nextInst;
        setDispatch(1'b1, 1'b1, physTag_t'(randBits(8)), physTag_t'(randBits(8)));
        nextCycle();
        expectIssue(1'b0, wantInst);
        nextCycle();
        expectIssue(1'b1, wantInst);  // two cycles after dispatch
        drainIssues();
        finishTest("ready at dispatch");

        issuedBefore = issuedCount;
        for (int k = 0; k < 6; k++) begin
            tagA[k]  = physTag_t'(randBits(8));
            tagB[k]  = physTag_t'(randBits(8));
            needB[k] = 1'(randBits(1));
            setDispatch(1'b0, !needB[k], tagA[k], tagB[k]);
            nextCycle();
        end
        repeat (4) nextCycle();
        if (issuedCount != issuedBefore) begin
            errors++;
            $display("ERR %0t: entry issued before its operand was broadcast", $time);
        end
        for (int k = 5; k >= 0; k--) begin
            setBroadcast(tagA[k]);
            nextCycle();
            if (needB[k]) begin
                setBroadcast(tagB[k]);
                nextCycle();
            end
        end
        drainIssues();
        finishTest("wakeup by broadcast");

        wantInst  = nextInst;
        sharedTag = physTag_t'(randBits(8));
        setDispatch(1'b0, 1'b1, sharedTag, physTag_t'(randBits(8)));
        setBroadcast(sharedTag);  // same cycle as the dispatch
        nextCycle();
        expectIssue(1'b0, wantInst);
        nextCycle();
        expectIssue(1'b1, wantInst);
        drainIssues();
        finishTest("bypass at dispatch");

        firstInst = nextInst;
        sharedTag = physTag_t'(randBits(8));
        for (int k = 0; k < 5; k++) begin
            setDispatch(1'b0, 1'b1, sharedTag, physTag_t'(randBits(8)));
            nextCycle();
        end
        setBroadcast(sharedTag);
        nextCycle();
        nextCycle();
        for (int k = 0; k < 5; k++) begin
            expectIssue(1'b1, firstInst + k);  // one per cycle, oldest first
            nextCycle();
        end
        drainIssues();
        finishTest("oldest first");

        sharedTag = physTag_t'(randBits(8));
        for (int k = 0; k < depth; k++) begin
            setDispatch(1'b1, 1'b0, physTag_t'(randBits(8)), sharedTag);
            nextCycle();
        end
        if (full !== 1'b1) begin
            errors++;
            $display("ERR %0t: full low after %0d dispatches", $time, depth);
        end
        setBroadcast(sharedTag);
        nextCycle();
        waited = 0;
        while (full === 1'b1 && waited < drainLimit) begin
            nextCycle();
            waited++;
        end
        if (full !== 1'b0) begin
            errors++;
            $display("full never dropped after the entries were woken up");
        end
        drainIssues();
        finishTest("full and reclaim");

        $display("tests %0d, errors %0d, dispatched %0d, issued %0d", testsRun, errors,
                 dispatchedCount, issuedCount);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/rsControl.sv ====
`timescale 1ns/100ps
`include "rsConfig_macros.svh"

module rsControl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispatch,
    input  logic                 pickValid,
    input  rsQueuePkg::rsIndex_t pickIndex,
    rsSlotIf.control             slot,
    output rsQueuePkg::rsIndex_t head,
    output logic                 full
);
    import rsQueuePkg::*;

    entryState_e state [`RS_DEPTH];
    rsIndex_t    tail;

    // new entries always land at the tail
    assign slot.allocate   = dispatch;
    assign slot.allocIndex = tail;
    assign slot.issue      = pickValid;
    assign slot.issueIndex = pickIndex;

    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < `RS_DEPTH; i++) begin
                state[i] <= slotFree;
            end
        end else begin
            // reclaim one issued entry per cycle, in order
            if (state[head] == slotIssued) begin
                state[head] <= slotFree;
                head        <= head + 1'b1;
            end
            if (pickValid) begin
                state[pickIndex] <= slotIssued;
            end
            if (dispatch) begin
                state[tail] <= slotWaiting;
                tail        <= tail + 1'b1;
            end
        end
    end

    always_comb begin
        full = 1'b1;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (state[i] == slotFree) begin
                full = 1'b0;
            end
        end
    end

    // no back-pressure, the dispatcher has to watch full
    noDispatchWhenFull: assert property (
        @(posedge clk) disable iff (reset) dispatch |-> !full
    ) else $error("dispatch while station full");

    // the picker must only see entries still waiting here
    pickIsWaiting: assert property (
        @(posedge clk) disable iff (reset) pickValid |-> state[pickIndex] == slotWaiting
    ) else $error("picked slot %0d is not waiting", pickIndex);

endmodule

// ==== verilog/rsIsaPkg.sv ====
`include "rsConfig_macros.svh"

package rsIsaPkg;

    typedef logic [`RS_TAG_BITS-1:0] physTag_t;

    // alu operation field as decoded upstream
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluSll  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluSlt  = 4'd8,
        aluSltu = 4'd9,
        aluLui  = 4'd10,
        aluPass = 4'd11
    } aluOp_e;

    typedef struct packed {
        logic [`RS_INST_BITS-1:0] instNum;
        physTag_t                 rd;
        aluOp_e                   aluOp;
        logic [2:0]               funct3;
        logic                     aluSrc2;   // immediate as second operand
        logic                     memToReg;
        logic                     memRead;
        logic                     memWrite;
        logic [`RS_IMM_BITS-1:0]  imm;
    } rsPayload_t;

endpackage

// ==== verilog/rsIssueSelect.sv ====
`timescale 1ns/100ps
`include "rsConfig_macros.svh"

module rsIssueSelect (
    input  rsQueuePkg::readyVec_t readyVec,
    input  rsQueuePkg::rsIndex_t  head,
    output logic                  pickValid,
    output rsQueuePkg::rsIndex_t  pickIndex
);
    import rsQueuePkg::*;

    readyVec_t rotated;   // bit 0 is the head slot
    rsIndex_t  offset;    // distance of the oldest ready entry from head

    assign rotated = readyVec_t'({readyVec, readyVec} >> head);

    // lowest set bit wins, so scan downwards
    always_comb begin
        offset = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (rotated[i]) begin
                offset = rsIndex_t'(i);
            end
        end
    end

    assign pickValid = |readyVec;
    assign pickIndex = head + offset;  // wraps with the index width

endmodule

// ==== verilog/rsPayloadRam.sv ====
`timescale 1ns/100ps
`include "rsConfig_macros.svh"

module rsPayloadRam (
    input  logic                 clk,
    input  logic                 reset,
    rsSlotIf.storage             slot,
    input  rsIsaPkg::rsPayload_t dispatchPayload,
    output rsIsaPkg::rsPayload_t issuePayload,
    output logic                 issueValid
);
    import rsIsaPkg::*;

    rsPayload_t mem [`RS_DEPTH];

    always_ff @(posedge clk) begin
        if (slot.allocate) begin
            mem[slot.allocIndex] <= dispatchPayload;
        end
        // output holds its last value between issues
        if (slot.issue) begin
            issuePayload <= mem[slot.issueIndex];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= slot.issue;  // one pulse per issued entry
        end
    end

endmodule

// ==== verilog/rsQueuePkg.sv ====
`include "rsConfig_macros.svh"

package rsQueuePkg;

    typedef logic [$clog2(`RS_DEPTH)-1:0] rsIndex_t;

    // lifetime of one slot
    typedef enum logic [1:0] {
        slotFree    = 2'd0,
        slotWaiting = 2'd1,
        slotIssued  = 2'd2   // sent to the alu, held until head passes
    } entryState_e;

    typedef logic [`RS_DEPTH-1:0] readyVec_t;

endpackage

// ==== verilog/rsSlotIf.sv ====
`timescale 1ns/100ps

interface rsSlotIf;
    import rsQueuePkg::*;

    logic     allocate;     // write the dispatched entry
    rsIndex_t allocIndex;
    logic     issue;        // read out the picked entry
    rsIndex_t issueIndex;

    modport control (
        output allocate, allocIndex, issue, issueIndex
    );

    modport storage (
        input allocate, allocIndex, issue, issueIndex
    );

endinterface

// ==== verilog/rsTop.sv ====
`timescale 1ns/100ps
`include "rsConfig_macros.svh"

module rsTop (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   dispatch,
    input  logic [`RS_INST_BITS-1:0]               instNum,
    input  rsIsaPkg::physTag_t                     rd,
    input  rsIsaPkg::aluOp_e                       aluOp,
    input  logic [2:0]                             funct3,
    input  logic                                   aluSrc2,
    input  logic                                   memToReg,
    input  logic                                   memRead,
    input  logic                                   memWrite,
    input  logic [`RS_IMM_BITS-1:0]                imm,
    input  rsIsaPkg::physTag_t                     src1Tag,
    input  rsIsaPkg::physTag_t                     src2Tag,
    input  logic                                   src1Ready,
    input  logic                                   src2Ready,
    input  logic [`RS_NUM_BUSES-1:0]               wbValid,
    input  rsIsaPkg::physTag_t [`RS_NUM_BUSES-1:0] wbTags,  // last bus is the load return
    output logic                                   full,
    output logic                                   issueValid,
    output logic [`RS_INST_BITS-1:0]               issueInstNum,
    output rsIsaPkg::physTag_t                     issueRd,
    output rsIsaPkg::aluOp_e                       issueAluOp,
    output logic [2:0]                             issueFunct3,
    output logic                                   issueAluSrc2,
    output logic                                   issueMemToReg,
    output logic                                   issueMemRead,
    output logic                                   issueMemWrite,
    output logic [`RS_IMM_BITS-1:0]                issueImm,
    output rsIsaPkg::physTag_t                     issueSrc1Tag,
    output rsIsaPkg::physTag_t                     issueSrc2Tag
);
    import rsIsaPkg::*;
    import rsQueuePkg::*;

    rsPayload_t dispatchPayload;
    rsPayload_t issuePayload;
    readyVec_t  readyVec;
    rsIndex_t   head;
    rsIndex_t   pickIndex;
    logic       pickValid;

    rsSlotIf slot ();

    assign dispatchPayload = '{
        instNum:  instNum,
        rd:       rd,
        aluOp:    aluOp,
        funct3:   funct3,
        aluSrc2:  aluSrc2,
        memToReg: memToReg,
        memRead:  memRead,
        memWrite: memWrite,
        imm:      imm
    };

    assign issueInstNum  = issuePayload.instNum;
    assign issueRd       = issuePayload.rd;
    assign issueAluOp    = issuePayload.aluOp;
    assign issueFunct3   = issuePayload.funct3;
    assign issueAluSrc2  = issuePayload.aluSrc2;
    assign issueMemToReg = issuePayload.memToReg;
    assign issueMemRead  = issuePayload.memRead;
    assign issueMemWrite = issuePayload.memWrite;
    assign issueImm      = issuePayload.imm;

    rsControl control (
        .clk       (clk),
        .reset     (reset),
        .dispatch  (dispatch),
        .pickValid (pickValid),
        .pickIndex (pickIndex),
        .slot      (slot),
        .head      (head),
        .full      (full)
    );

    rsWakeup wakeup (
        .clk          (clk),
        .reset        (reset),
        .slot         (slot),
        .src1Tag      (src1Tag),
        .src2Tag      (src2Tag),
        .src1Ready    (src1Ready),
        .src2Ready    (src2Ready),
        .wbValid      (wbValid),
        .wbTags       (wbTags),
        .readyVec     (readyVec),
        .issueSrc1Tag (issueSrc1Tag),
        .issueSrc2Tag (issueSrc2Tag)
    );

    rsPayloadRam payloadRam (
        .clk             (clk),
        .reset           (reset),
        .slot            (slot),
        .dispatchPayload (dispatchPayload),
        .issuePayload    (issuePayload),
        .issueValid      (issueValid)
    );

    rsIssueSelect issueSelect (
        .readyVec  (readyVec),
        .head      (head),
        .pickValid (pickValid),
        .pickIndex (pickIndex)
    );

endmodule

// ==== verilog/rsWakeup.sv ====
`timescale 1ns/100ps
`include "rsConfig_macros.svh"

module rsWakeup (
    input  logic                                   clk,
    input  logic                                   reset,
    rsSlotIf.storage                               slot,
    input  rsIsaPkg::physTag_t                     src1Tag,
    input  rsIsaPkg::physTag_t                     src2Tag,
    input  logic                                   src1Ready,
    input  logic                                   src2Ready,
    input  logic [`RS_NUM_BUSES-1:0]               wbValid,
    input  rsIsaPkg::physTag_t [`RS_NUM_BUSES-1:0] wbTags,
    output rsQueuePkg::readyVec_t                  readyVec,
    output rsIsaPkg::physTag_t                     issueSrc1Tag,
    output rsIsaPkg::physTag_t                     issueSrc2Tag
);
    import rsIsaPkg::*;
    import rsQueuePkg::*;

    physTag_t  tag1 [`RS_DEPTH];
    physTag_t  tag2 [`RS_DEPTH];
    readyVec_t rdy1;
    readyVec_t rdy2;
    readyVec_t pending;   // allocated and not yet issued

    // any valid result bus carrying this tag
    function automatic logic busHit(physTag_t tag);
        logic hit;
        hit = 1'b0;
        for (int b = 0; b < `RS_NUM_BUSES; b++) begin
            if (wbValid[b] && wbTags[b] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            rdy1    <= '0;
            rdy2    <= '0;
            pending <= '0;
        end else begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (pending[i] && !rdy1[i] && busHit(tag1[i])) begin
                    rdy1[i] <= 1'b1;
                end
                if (pending[i] && !rdy2[i] && busHit(tag2[i])) begin
                    rdy2[i] <= 1'b1;
                end
            end
            if (slot.allocate) begin
                pending[slot.allocIndex] <= 1'b1;
                rdy1[slot.allocIndex]    <= src1Ready | busHit(src1Tag);  // same-cycle bypass
                rdy2[slot.allocIndex]    <= src2Ready | busHit(src2Tag);
            end
            if (slot.issue) begin
                pending[slot.issueIndex] <= 1'b0;
                rdy1[slot.issueIndex]    <= 1'b0;
                rdy2[slot.issueIndex]    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (slot.allocate) begin
            tag1[slot.allocIndex] <= src1Tag;
            tag2[slot.allocIndex] <= src2Tag;
        end
        if (slot.issue) begin
            issueSrc1Tag <= tag1[slot.issueIndex];
            issueSrc2Tag <= tag2[slot.issueIndex];
        end
    end

    assign readyVec = pending & rdy1 & rdy2;

    issuedWasReady: assert property (
        @(posedge clk) disable iff (reset)
        slot.issue |-> rdy1[slot.issueIndex] && rdy2[slot.issueIndex]
    ) else $error("slot %0d issued with an operand outstanding", slot.issueIndex);

endmodule
